//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := uartTxDemo_tb
FILELIST := verilog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- dv/txModule_checker.sv
// Transmitter protocol assertions
`default_nettype none

module txModule_checker
    import uartPkg::*;
(
    input wire logic      CLOCK,
    input wire logic      RST_n,
    // Internal frame state of the transmitter
    input wire txState_e  state,
    // Handshake from the sequencer
    input wire logic      txEn,
    input wire uartByte_t txData,
    // Handshake back to the sequencer
    input wire logic      txDone,
    // Serial line
    input wire logic      TXD
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int failCount = 0;

    // Line rests high whenever no frame is in progress
    idleLineHigh: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        (state == TX_IDLE) |-> TXD
    ) else begin
        failCount++;
        $error("TXD is low while the transmitter is idle");
    end

    // Done is a single-cycle pulse
    doneOneCycle: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        txDone |=> !txDone
    ) else begin
        failCount++;
        $error("txDone stayed high for more than one cycle");
    end

    // Sender holds the byte until the done cycle
    dataHeld: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        (txEn && !txDone) |=> $stable(txData)
    ) else begin
        failCount++;
        $error("txData changed while txEn was high and txDone low");
    end

    // Done only comes while the high stop bit is on the line
    doneInStop: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        txDone |-> TXD
    ) else begin
        failCount++;
        $error("txDone pulsed while the line was low");
    end

endmodule

`default_nettype wire

//--- dv/uartTxDemo_tb.sv
// UART transmit demo testbench
`default_nettype none
`include "uart_macros.svh"

module uartTxDemo_tb
    import uartPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int bitCycles = `UART_BAUD_DIV;
    localparam int frameCycles = 10 * bitCycles;
    localparam int midCycle = bitCycles / 2;
    localparam int backToBackMsgs = 5;
    localparam int totalMsgs = 2 + backToBackMsgs;
    // Four times the line time of all messages, plus reset, gaps and slack
    localparam int timeoutCycles =
        4 * totalMsgs * `UART_MSG_LEN * frameCycles + 8 + totalMsgs * 20 + 500;
    localparam int unsigned randomSeed = 72;

    logic CLOCK;
    logic RST_n;
    logic start;
    wire logic busy;
    wire logic msgDone;
    wire logic TXD;

    // Monitor state
    logic busyWatch = 1'b0;
    int doneCount = 0;
    int cycleCount = 0;
    int unsigned seedDraw;

    uartTxDemo DUT (
        .CLOCK   (CLOCK),
        .RST_n   (RST_n),
        .start   (start),
        .busy    (busy),
        .msgDone (msgDone),
        .TXD     (TXD)
    );

    // Protocol assertions inside every transmitter
    bind txModule txModule_checker uTxCheck (
        .CLOCK  (CLOCK),
        .RST_n  (RST_n),
        .state  (state),
        .txEn   (txEn),
        .txData (txData),
        .txDone (txDone),
        .TXD    (TXD)
    );

    // 10 ns clock
    initial begin
        CLOCK = 1'b0;
        forever #5 CLOCK = ~CLOCK;
    end

    // Expected message, byte k of the line order
    function automatic uartByte_t expectedByte(input int k);
        uartByte_t value;
        case (k)
            0: value = `UART_MSG_BYTE0;
            1: value = `UART_MSG_BYTE1;
            default: value = `UART_MSG_BYTE2;
        endcase
        return value;
    endfunction

    task automatic checkByte(input string name, input uartByte_t expected,
                             input uartByte_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Busy must stay high for the whole message
    always @(negedge CLOCK) begin
        if (busyWatch) begin
            checkBit("busy", 1'b1, busy);
        end
    end

    // Pulse counter, sampled before the edge updates msgDone
    always @(posedge CLOCK) begin
        if (RST_n && (msgDone === 1'b1)) begin
            doneCount++;
        end
    end

    // Run limit
    always @(posedge CLOCK) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // Serial decoder, entered at a negedge with the line idle
    // Checks each bit window at its first, middle and last cycle
    task automatic receiveFrame(output uartByte_t data, output logic startBit,
                                output logic stopBit);
        logic [9:0] bitLevel;
        logic windowLevel;
        int idleSeen;
        int bitPos;
        int cyc;
        idleSeen = 0;
        bitLevel = '0;
        windowLevel = 1'b1;
        while (TXD !== 1'b0) begin
            idleSeen++;
            @(negedge CLOCK);
        end
        if (idleSeen == 0) begin
            $display("Error: a frame began without TXD idling high first");
            $display("Checks failed");
            $fatal(1);
        end
        for (int i = 0; i < frameCycles; i++) begin
            if (i > 0) begin
                @(negedge CLOCK);
            end
            bitPos = i / bitCycles;
            cyc = i % bitCycles;
            if (cyc == 0) begin
                windowLevel = TXD;
            end
            if (cyc == midCycle) begin
                bitLevel[bitPos] = TXD;
                checkBit("TXD at bit middle", windowLevel, TXD);
            end
            if (cyc == bitCycles - 1) begin
                checkBit("TXD at bit end", windowLevel, TXD);
            end
        end
        startBit = bitLevel[0];
        data = bitLevel[8:1];
        stopBit = bitLevel[9];
    endtask

    // Decode all bytes of one message and compare them in order
    task automatic receiveMessage();
        uartByte_t data;
        logic startBit;
        logic stopBit;
        for (int k = 0; k < `UART_MSG_LEN; k++) begin
            receiveFrame(data, startBit, stopBit);
            checkByte("TXD byte", expectedByte(k), data);
            checkBit("TXD start bit", 1'b0, startBit);
            checkBit("TXD stop bit", 1'b1, stopBit);
            if (k < `UART_MSG_LEN - 1) begin
                // One idle cycle between frames
                @(negedge CLOCK);
                checkBit("TXD between frames", 1'b1, TXD);
            end
        end
    endtask

    // One-cycle start request, busy rises right after
    task automatic pulseStart();
        start = 1'b1;
        @(negedge CLOCK);
        start = 1'b0;
        checkBit("busy", 1'b1, busy);
        checkBit("msgDone", 1'b0, msgDone);
        busyWatch = 1'b1;
    endtask

    // End of message: msgDone pulses as busy falls
    task automatic finishMessage();
        busyWatch = 1'b0;
        @(negedge CLOCK);
        checkBit("msgDone", 1'b1, msgDone);
        checkBit("busy", 1'b0, busy);
        checkBit("TXD", 1'b1, TXD);
    endtask

    // Idle line, nothing in progress
    task automatic expectQuietLine(input int cycles);
        repeat (cycles) begin
            @(negedge CLOCK);
            checkBit("TXD", 1'b1, TXD);
            checkBit("busy", 1'b0, busy);
            checkBit("msgDone", 1'b0, msgDone);
        end
    endtask

    task automatic runMessage(input int gap);
        if (gap > 0) begin
            expectQuietLine(gap);
        end
        pulseStart();
        receiveMessage();
        finishMessage();
    endtask

    task automatic testReset();
        RST_n = 1'b0;
        start = 1'b0;
        repeat (8) begin
            @(negedge CLOCK);
            checkBit("TXD", 1'b1, TXD);
            checkBit("busy", 1'b0, busy);
            checkBit("msgDone", 1'b0, msgDone);
        end
        RST_n = 1'b1;
        expectQuietLine(4);
    endtask

    task automatic testOneMessage();
        runMessage(3);
        @(negedge CLOCK);
        checkCount("msgDone pulses", 1, doneCount);
    endtask

    // Start during byte 1 must not restart or extend the message
    task automatic testStartWhileBusy();
        int baseCount;
        baseCount = doneCount;
        pulseStart();
        fork
            receiveMessage();
            begin
                repeat (12 * bitCycles) @(negedge CLOCK);
                start = 1'b1;
                @(negedge CLOCK);
                start = 1'b0;
            end
        join
        finishMessage();
        // No fourth frame without a new start
        expectQuietLine(2 * frameCycles);
        checkCount("msgDone pulses", baseCount + 1, doneCount);
    endtask

    // Random gaps, and every other message started as busy falls
    task automatic testBackToBack();
        int baseCount;
        int gap;
        baseCount = doneCount;
        for (int m = 0; m < backToBackMsgs; m++) begin
            if (m % 2 == 1) begin
                gap = 0;
            end else begin
                gap = int'($urandom % 21);
            end
            runMessage(gap);
        end
        @(negedge CLOCK);
        checkCount("msgDone pulses", baseCount + backToBackMsgs, doneCount);
    endtask

    initial begin
        RST_n = 1'b0;
        start = 1'b0;
        seedDraw = $urandom(randomSeed);
        testReset();
        testOneMessage();
        testStartWhileBusy();
        testBackToBack();
        if (DUT.uTx.uTxCheck.failCount != 0) begin
            $display("Error: %0d transmitter assertions failed",
                     DUT.uTx.uTxCheck.failCount);
            $display("Checks failed");
            $fatal(1);
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src/msgSequencer.sv
// UART message sequencer
`default_nettype none
`include "uart_macros.svh"

module msgSequencer
    import uartPkg::*;
(
    input  wire logic CLOCK,
    input  wire logic RST_n,
    // One-cycle request to send the message
    input  wire logic start,
    // Done pulse from the transmitter
    input  wire logic txDone,
    // Byte handed to the transmitter
    output uartByte_t txData,
    // Enable toward the transmitter
    output logic      txEn,
    // High while a message is in progress
    output logic      busy,
    // One-cycle pulse after the last byte
    output logic      msgDone
);

    // Byte index width, at least one bit
    localparam int idxWidth = (`UART_MSG_LEN > 2) ? $clog2(`UART_MSG_LEN) : 1;
    localparam logic [idxWidth-1:0] lastIdx = idxWidth'(`UART_MSG_LEN - 1);

    seqState_e           state;
    logic [idxWidth-1:0] byteIdx;
    logic                lastByte;

    // Message byte lookup
    function automatic uartByte_t msgByte(input logic [idxWidth-1:0] idx);
        uartByte_t value;
        case (idx)
            idxWidth'(0): value = `UART_MSG_BYTE0;
            idxWidth'(1): value = `UART_MSG_BYTE1;
            idxWidth'(2): value = `UART_MSG_BYTE2;
            default:      value = `UART_MSG_BYTE0;
        endcase
        return value;
    endfunction

    assign lastByte = (byteIdx == lastIdx);

    // Byte stays fixed for the whole handshake since byteIdx only
    // moves on the done cycle
    assign txData = msgByte(byteIdx);

    // Enable drops in the done cycle itself
    // Next byte is raised on the following cycle, leaving one idle line cycle
    assign txEn = (state == SEQ_SEND) || ((state == SEQ_WAIT) && !txDone);

    // Busy from send of byte 0 until msgDone
    assign busy = (state != SEQ_IDLE);

    // Step machine
    // One pass of SEND then WAIT per message byte
    always_ff @(posedge CLOCK or negedge RST_n) begin
        if (!RST_n) begin
            state   <= SEQ_IDLE;
            byteIdx <= '0;
            msgDone <= 1'b0;
        end else begin
            msgDone <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    // Start only counts when idle
                    if (start) begin
                        state   <= SEQ_SEND;
                        byteIdx <= '0;
                    end
                end

                SEQ_SEND: begin
                    // Transmitter is idle here and takes the byte
                    state <= SEQ_WAIT;
                end

                SEQ_WAIT: begin
                    // Start is ignored, the frame is still on the line
                    if (txDone) begin
                        if (lastByte) begin
                            state   <= SEQ_IDLE;
                            msgDone <= 1'b1;
                        end else begin
                            byteIdx <= byteIdx + 1'b1;
                            state   <= SEQ_SEND;
                        end
                    end
                end

                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/txModule.sv
// UART 8N1 serial transmitter
`default_nettype none

module txModule
    import uartPkg::*;
#(
    // Clock cycles per serial bit, must be 2 or more
    parameter int clocksPerBit = 16
)
(
    input  wire logic      CLOCK,
    input  wire logic      RST_n,
    // Byte to send, held stable by the sender while txEn is high
    input  wire uartByte_t txData,
    // Request to send txData
    input  wire logic      txEn,
    // One-cycle pulse in the last cycle of the stop bit
    output logic           txDone,
    // Serial line, idles high
    output logic           TXD
);

    // Counter width covers 0 .. clocksPerBit-1
    localparam int cntWidth = (clocksPerBit > 2) ? $clog2(clocksPerBit) : 1;
    localparam logic [cntWidth-1:0] lastCount = cntWidth'(clocksPerBit - 1);

    // Index of the last data bit
    localparam logic [2:0] lastBit = 3'd7;

    txState_e            state;
    logic [cntWidth-1:0] bitCnt;
    logic [2:0]          bitIdx;
    uartByte_t           shiftReg;

    // Last cycle of the current bit window
    logic bitEnd;
    // Byte accepted this cycle
    logic loadByte;
    // Next data bit moves to the line this cycle
    logic shiftBit;

    assign bitEnd = (bitCnt == lastCount);
    assign loadByte = (state == TX_IDLE) && txEn;
    assign shiftBit = bitEnd && ((state == TX_START) || (state == TX_DATA));

    // Done pulse lines up with the final stop bit cycle
    assign txDone = (state == TX_STOP) && bitEnd;

    // Bit period counter
    // Free runs while a frame is on the line, wraps at each bit boundary
    always_ff @(posedge CLOCK or negedge RST_n) begin
        if (!RST_n) begin
            bitCnt <= '0;
        end else if (state == TX_IDLE) begin
            bitCnt <= '0;
        end else if (bitEnd) begin
            bitCnt <= '0;
        end else begin
            bitCnt <= bitCnt + 1'b1;
        end
    end

    // Data shift register
    // Loaded when the byte is accepted, shifted right as each bit goes out
    always_ff @(posedge CLOCK) begin
        if (loadByte) begin
            shiftReg <= txData;
        end else if (shiftBit) begin
            shiftReg <= {1'b0, shiftReg[7:1]};
        end
    end

    // Frame state machine and registered line
    always_ff @(posedge CLOCK or negedge RST_n) begin
        if (!RST_n) begin
            state  <= TX_IDLE;
            bitIdx <= '0;
            TXD    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    // Start bit appears on the cycle after acceptance
                    if (txEn) begin
                        state <= TX_START;
                        TXD   <= 1'b0;
                    end else begin
                        TXD <= 1'b1;
                    end
                end

                TX_START: begin
                    // Data bit 0 follows the start bit
                    if (bitEnd) begin
                        state  <= TX_DATA;
                        bitIdx <= '0;
                        TXD    <= shiftReg[0];
                    end
                end

                TX_DATA: begin
                    if (bitEnd) begin
                        if (bitIdx == lastBit) begin
                            // All eight bits sent, stop bit is high
                            state <= TX_STOP;
                            TXD   <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            TXD    <= shiftReg[0];
                        end
                    end
                end

                TX_STOP: begin
                    // Line stays high into idle
                    if (bitEnd) begin
                        state <= TX_IDLE;
                    end
                end

                default: begin
                    state <= TX_IDLE;
                    TXD   <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/uartPkg.sv
// UART demo types
`default_nettype none

package uartPkg;

    // One data byte as carried on the enable/done handshake
    typedef logic [7:0] uartByte_t;

    // Transmitter states
    // TX_IDLE holds the line high and waits for txEn
    // TX_START drives the start bit low
    // TX_DATA shifts out eight data bits, LSB first
    // TX_STOP drives the stop bit high and pulses txDone at its end
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } txState_e;

    // Sequencer states
    // SEQ_IDLE waits for a start request
    // SEQ_SEND presents a byte to the idle transmitter
    // SEQ_WAIT holds the byte until txDone comes back
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_SEND = 2'd1,
        SEQ_WAIT = 2'd2
    } seqState_e;

    // Encoding 2'd3 of seqState_e is unused
    // The sequencer falls back to SEQ_IDLE if it ever lands there

endpackage

`default_nettype wire

//--- src/uartTxDemo.sv
// UART transmit demo top
`default_nettype none
`include "uart_macros.svh"

module uartTxDemo
    import uartPkg::*;
(
    input  wire logic CLOCK,
    input  wire logic RST_n,
    // Request to send the message
    input  wire logic start,
    // Message in progress
    output wire logic busy,
    // End of message pulse
    output wire logic msgDone,
    // Serial line out
    output wire logic TXD
);

    // Handshake between sequencer and transmitter
    uartByte_t txData;
    logic      txEn;
    logic      txDone;

    // Message source
    msgSequencer uSeq (
        .CLOCK   (CLOCK),
        .RST_n   (RST_n),
        .start   (start),
        .txDone  (txDone),
        .txData  (txData),
        .txEn    (txEn),
        .busy    (busy),
        .msgDone (msgDone)
    );

    // Serial framer at the demo bit rate
    txModule #(
        .clocksPerBit (`UART_BAUD_DIV)
    ) uTx (
        .CLOCK  (CLOCK),
        .RST_n  (RST_n),
        .txData (txData),
        .txEn   (txEn),
        .txDone (txDone),
        .TXD    (TXD)
    );

endmodule

`default_nettype wire

//--- src/uart_macros.svh
// UART demo constants
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Serial line timing

// Clock cycles per serial bit
// Kept small so a full message simulates quickly
`define UART_BAUD_DIV 16

// Message contents

// Number of bytes in one message
`define UART_MSG_LEN 3

// First byte on the line
`define UART_MSG_BYTE0 8'hAB

// Second byte
`define UART_MSG_BYTE1 8'hCD

// Last byte, followed by the msgDone pulse
`define UART_MSG_BYTE2 8'hEF

// One frame is start bit, eight data bits and stop bit
// Bit count per frame is fixed by the 8N1 format

`endif

//--- verilog.f
+incdir+src
src/uartPkg.sv
src/txModule.sv
src/msgSequencer.sv
src/uartTxDemo.sv
dv/txModule_checker.sv
dv/uartTxDemo_tb.sv
